//--- include/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// datapath and register index widths
`define XLEN        32
`define REG_IDX_W   5
`define REG_TAG_W   6

// tag 32 never matches a real register index
`define NO_RD       6'd32

// return address is pc plus one instruction
`define LINK_OFFSET 32'd4

// RV32I base opcodes
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_BRANCH  7'b1100011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_ALU_IR  7'b0010011
`define OPC_ALU_RR  7'b0110011

// funct3 for integer ops
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 for conditional branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif

//--- verilog/decode_pkg.sv
`include "decode_settings.svh"

package decode_pkg;

	// destination tag, one bit wider than an index so NO_RD never matches
	typedef logic [`REG_TAG_W-1:0] reg_tag_t;

	typedef enum logic [3:0]
	{
		ALU_NONE,
		ALU_ADD,
		ALU_SUB,
		ALU_SLT,
		ALU_SLTU,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA
	} alu_op_t;

	typedef enum logic [2:0]
	{
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU
	} branch_op_t;

	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_t;

	typedef enum logic [1:0] {SRC1_REG, SRC1_PC, SRC1_ZERO} src1_sel_t;

	typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_LINK, SRC2_ZERO} src2_sel_t;

endpackage

//--- verilog/instr_decoder.sv
`include "decode_settings.svh"

module instr_decoder
(
	input  logic                    if_valid,
	input  logic [`XLEN-1:0]        instr_dec,
	output logic [`REG_IDX_W-1:0]   rs1_idx,
	output logic [`REG_IDX_W-1:0]   rs2_idx,
	output logic                    rs1_used,
	output logic                    rs2_used,
	output decode_pkg::src1_sel_t   src1_sel,
	output decode_pkg::src2_sel_t   src2_sel,
	output logic [`XLEN-1:0]        imm,
	output decode_pkg::alu_op_t     alu_op,
	output decode_pkg::branch_op_t  branch_op,
	output logic                    is_load,
	output logic                    is_store,
	output logic                    is_jal,
	output logic                    is_jalr,
	output decode_pkg::mem_size_t   mem_size,
	output logic                    mem_unsigned,
	output decode_pkg::reg_tag_t    rd_tag
);

	logic [`XLEN-1:0] instr;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`REG_IDX_W-1:0] rd;
	logic is_lui, is_auipc, is_branch, is_alu_ir, is_alu_rr;
	logic r_type, i_type, s_type, b_type, j_type, u_type;
	logic f7_base, f7_alt;
	logic alu_base; // ops that take the plain funct3 meaning

	assign instr = if_valid ? instr_dec : '0; // no fetch means no instruction

	assign opcode  = instr[6:0];
	assign rd      = instr[11:7];
	assign funct3  = instr[14:12];
	assign rs1_idx = instr[19:15];
	assign rs2_idx = instr[24:20];
	assign funct7  = instr[31:25];

	assign is_lui    = (opcode == `OPC_LUI);
	assign is_auipc  = (opcode == `OPC_AUIPC);
	assign is_jal    = (opcode == `OPC_JAL);
	assign is_jalr   = (opcode == `OPC_JALR);
	assign is_branch = (opcode == `OPC_BRANCH);
	assign is_load   = (opcode == `OPC_LOAD);
	assign is_store  = (opcode == `OPC_STORE);
	assign is_alu_ir = (opcode == `OPC_ALU_IR);
	assign is_alu_rr = (opcode == `OPC_ALU_RR);

	// format classes
	assign r_type = is_alu_rr;
	assign i_type = is_load | is_alu_ir | is_jalr;
	assign s_type = is_store;
	assign b_type = is_branch;
	assign j_type = is_jal;
	assign u_type = is_lui | is_auipc;

	assign f7_base  = (funct7 == `F7_BASE);
	assign f7_alt   = (funct7 == `F7_ALT);
	assign alu_base = is_alu_ir | (is_alu_rr & f7_base);

	assign rs1_used = r_type | i_type | s_type | b_type;
	assign rs2_used = r_type | s_type | b_type;

	assign src1_sel = is_auipc ? decode_pkg::SRC1_PC :
		(is_lui | is_jal) ? decode_pkg::SRC1_ZERO : decode_pkg::SRC1_REG;

	always_comb
	begin
		if (is_jal || is_jalr)
			src2_sel = decode_pkg::SRC2_LINK;
		else if (r_type || b_type)
			src2_sel = decode_pkg::SRC2_REG;
		else if (i_type || s_type || u_type)
			src2_sel = decode_pkg::SRC2_IMM;
		else
			src2_sel = decode_pkg::SRC2_ZERO;
	end

	// sign-extended immediate per format
	always_comb
	begin
		if (i_type)
			imm = {{20{instr[31]}}, instr[31:20]};
		else if (s_type)
			imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
		else if (b_type)
			imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
		else if (j_type)
			imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
		else if (u_type)
			imm = {instr[31:12], 12'b0};
		else
			imm = '0;
	end

	always_comb
	begin
		alu_op = decode_pkg::ALU_NONE;
		if (is_auipc || is_load || is_store || (alu_base && funct3 == `F3_ADD))
			alu_op = decode_pkg::ALU_ADD;
		else if ((is_alu_rr && f7_alt && funct3 == `F3_ADD) ||
			(is_branch && (funct3 == `F3_BEQ || funct3 == `F3_BNE)))
			alu_op = decode_pkg::ALU_SUB; // branch equality via subtract
		else if ((is_branch && (funct3 == `F3_BLT || funct3 == `F3_BGE)) ||
			(alu_base && funct3 == `F3_SLT))
			alu_op = decode_pkg::ALU_SLT;
		else if ((is_branch && (funct3 == `F3_BLTU || funct3 == `F3_BGEU)) ||
			(alu_base && funct3 == `F3_SLTU))
			alu_op = decode_pkg::ALU_SLTU;
		else if (alu_base && funct3 == `F3_AND)
			alu_op = decode_pkg::ALU_AND;
		else if (alu_base && funct3 == `F3_OR)
			alu_op = decode_pkg::ALU_OR;
		else if (alu_base && funct3 == `F3_XOR)
			alu_op = decode_pkg::ALU_XOR;
		else if (alu_base && funct3 == `F3_SLL)
			alu_op = decode_pkg::ALU_SLL;
		else if ((is_alu_ir || is_alu_rr) && funct3 == `F3_SR && f7_base)
			alu_op = decode_pkg::ALU_SRL;
		else if ((is_alu_ir || is_alu_rr) && funct3 == `F3_SR && f7_alt)
			alu_op = decode_pkg::ALU_SRA;
	end

	always_comb
	begin
		branch_op = decode_pkg::BR_NONE;
		if (is_branch)
		begin
			case (funct3)
				`F3_BEQ:  branch_op = decode_pkg::BR_EQ;
				`F3_BNE:  branch_op = decode_pkg::BR_NE;
				`F3_BLT:  branch_op = decode_pkg::BR_LT;
				`F3_BGE:  branch_op = decode_pkg::BR_GE;
				`F3_BLTU: branch_op = decode_pkg::BR_LTU;
				`F3_BGEU: branch_op = decode_pkg::BR_GEU;
				default:  branch_op = decode_pkg::BR_NONE;
			endcase
		end
	end

	assign mem_size = (funct3[1:0] == 2'b00) ? decode_pkg::MEM_BYTE :
		(funct3[1:0] == 2'b01) ? decode_pkg::MEM_HALF : decode_pkg::MEM_WORD;
	assign mem_unsigned = (is_load | is_store) & funct3[2]; // lbu and lhu

	assign rd_tag = (r_type | i_type | u_type | j_type) ? {1'b0, rd} : `NO_RD;

endmodule

//--- verilog/reg_file.sv
`include "decode_settings.svh"

module reg_file
(
	input  logic                   cpu_clk,
	input  logic                   cpu_rstn,
	input  logic                   wr_valid,
	input  decode_pkg::reg_tag_t   wr_tag,
	input  logic [`XLEN-1:0]       wr_data,
	input  logic [`REG_IDX_W-1:0]  rs1_idx,
	input  logic [`REG_IDX_W-1:0]  rs2_idx,
	output logic [`XLEN-1:0]       rf_data1,
	output logic [`XLEN-1:0]       rf_data2
);

	logic [`XLEN-1:0] regs [1:31]; // x0 is not stored

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_valid && wr_tag != '0 && wr_tag < `NO_RD)
			regs[wr_tag[`REG_IDX_W-1:0]] <= wr_data;
	end

	// reads see the old value until the write edge
	assign rf_data1 = (rs1_idx == '0) ? '0 : regs[rs1_idx];
	assign rf_data2 = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- verilog/operand_select.sv
`include "decode_settings.svh"

module operand_select
(
	input  logic [`REG_IDX_W-1:0]  rs_idx,
	input  logic                   rs_used,
	input  logic [`XLEN-1:0]       rf_data,
	input  decode_pkg::reg_tag_t   rd_ex,
	input  logic                   load_ex,
	input  logic [`XLEN-1:0]       alu_result_ex,
	input  decode_pkg::reg_tag_t   rd_mem,
	input  logic [`XLEN-1:0]       data_mem,
	input  logic                   load_wait_data,
	input  logic                   wr_valid_wb,
	input  decode_pkg::reg_tag_t   rd_wb,
	input  logic [`XLEN-1:0]       wr_data_wb,
	output logic [`XLEN-1:0]       fwd_data,
	output logic                   load_hazard
);

	decode_pkg::reg_tag_t rs_tag;
	logic idx_zero;
	logic hit_ex, hit_mem, hit_wb;

	assign rs_tag   = {1'b0, rs_idx}; // widened so NO_RD never hits
	assign idx_zero = (rs_idx == '0);
	assign hit_ex   = (rs_tag == rd_ex);
	assign hit_mem  = (rs_tag == rd_mem);
	assign hit_wb   = (rs_tag == rd_wb) && wr_valid_wb;

	// youngest producer wins
	always_comb
	begin
		if (idx_zero)
			fwd_data = '0;
		else if (hit_ex && !load_ex)
			fwd_data = alu_result_ex; // load data not there yet
		else if (hit_mem)
			fwd_data = data_mem;
		else if (hit_wb)
			fwd_data = wr_data_wb;
		else
			fwd_data = rf_data;
	end

	assign load_hazard = rs_used && !idx_zero &&
		((hit_ex && load_ex) || (hit_mem && load_wait_data));

endmodule

//--- verilog/ex_stage_reg.sv
`include "decode_settings.svh"

module ex_stage_reg
(
	input  logic                    cpu_clk,
	input  logic                    cpu_rstn,
	input  logic                    if_valid,
	input  logic [`XLEN-1:0]        pc_dec,
	input  decode_pkg::src1_sel_t   src1_sel,
	input  decode_pkg::src2_sel_t   src2_sel,
	input  logic [`XLEN-1:0]        imm,
	input  decode_pkg::alu_op_t     alu_op,
	input  decode_pkg::branch_op_t  branch_op,
	input  logic                    is_load,
	input  logic                    is_store,
	input  logic                    is_jal,
	input  logic                    is_jalr,
	input  decode_pkg::mem_size_t   mem_size,
	input  logic                    mem_unsigned,
	input  decode_pkg::reg_tag_t    rd_tag,
	input  logic [`XLEN-1:0]        fwd_data1,
	input  logic [`XLEN-1:0]        fwd_data2,
	input  logic                    load_hazard1,
	input  logic                    load_hazard2,
	input  logic                    ex_ready,
	input  logic                    branch_taken_ex,
	input  logic                    exception_met,
	output logic                    dec_ready,
	output logic                    jal_dec,
	output logic                    dec_valid,
	output decode_pkg::alu_op_t     alu_op_ex,
	output decode_pkg::branch_op_t  branch_op_ex,
	output logic [`XLEN-1:0]        src_data1_ex,
	output logic [`XLEN-1:0]        src_data2_ex,
	output logic [`XLEN-1:0]        imm_ex,
	output logic [`XLEN-1:0]        store_data_ex,
	output logic [`XLEN-1:0]        pc_ex,
	output logic                    load_ex,
	output logic                    store_ex,
	output logic                    jalr_ex,
	output decode_pkg::mem_size_t   mem_size_ex,
	output logic                    mem_unsigned_ex,
	output decode_pkg::reg_tag_t    rd_ex
);

	logic [`XLEN-1:0] src_data1, src_data2;
	logic stall, bubble, flush, kill;

	always_comb
	begin
		case (src1_sel)
			decode_pkg::SRC1_REG: src_data1 = fwd_data1;
			decode_pkg::SRC1_PC:  src_data1 = pc_dec; // auipc
			default:              src_data1 = '0;
		endcase
	end

	always_comb
	begin
		case (src2_sel)
			decode_pkg::SRC2_REG:  src_data2 = fwd_data2;
			decode_pkg::SRC2_IMM:  src_data2 = imm;
			decode_pkg::SRC2_LINK: src_data2 = pc_dec + `LINK_OFFSET; // link address
			default:               src_data2 = '0;
		endcase
	end

	assign stall     = load_hazard1 | load_hazard2;
	assign bubble    = stall | !if_valid;
	assign dec_ready = !stall && ex_ready;
	assign jal_dec   = is_jal && !stall;

	// a jalr in EX redirects fetch, so the instruction behind it dies
	assign flush = branch_taken_ex | exception_met | jalr_ex;
	assign kill  = flush | (ex_ready & bubble);

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			dec_valid    <= 1'b0;
			alu_op_ex    <= decode_pkg::ALU_NONE;
			branch_op_ex <= decode_pkg::BR_NONE;
			load_ex      <= 1'b0;
			store_ex     <= 1'b0;
			jalr_ex      <= 1'b0;
			rd_ex        <= `NO_RD;
		end
		else if (kill)
		begin
			dec_valid    <= 1'b0;
			alu_op_ex    <= decode_pkg::ALU_NONE;
			branch_op_ex <= decode_pkg::BR_NONE;
			load_ex      <= 1'b0;
			store_ex     <= 1'b0;
			jalr_ex      <= 1'b0;
			rd_ex        <= `NO_RD;
		end
		else if (ex_ready)
		begin
			dec_valid    <= 1'b1;
			alu_op_ex    <= alu_op;
			branch_op_ex <= branch_op;
			load_ex      <= is_load;
			store_ex     <= is_store;
			jalr_ex      <= is_jalr;
			rd_ex        <= rd_tag;
		end
	end

	// payload, pc and imm keep their value across bubbles
	always_ff @(posedge cpu_clk)
	begin
		if (kill)
		begin
			src_data1_ex  <= '0;
			src_data2_ex  <= '0;
			store_data_ex <= '0;
		end
		else if (ex_ready)
		begin
			src_data1_ex    <= src_data1;
			src_data2_ex    <= src_data2;
			store_data_ex   <= fwd_data2; // rs2 for stores
			imm_ex          <= imm;
			pc_ex           <= pc_dec;
			mem_size_ex     <= mem_size;
			mem_unsigned_ex <= mem_unsigned;
		end
	end

endmodule

//--- verilog/decode_stage.sv
`include "decode_settings.svh"

module decode_stage
(
	input  logic                    cpu_clk,
	input  logic                    cpu_rstn,
	input  logic                    if_valid,
	input  logic [`XLEN-1:0]        instr_dec,
	input  logic [`XLEN-1:0]        pc_dec,
	output logic                    dec_ready,
	output logic                    jal_dec,
	input  logic                    ex_ready,
	input  logic                    branch_taken_ex,
	input  logic                    exception_met,
	input  logic [`XLEN-1:0]        alu_result_ex,
	input  decode_pkg::reg_tag_t    rd_mem,
	input  logic [`XLEN-1:0]        data_mem,
	input  logic                    load_wait_data,
	input  logic                    wr_valid_wb,
	input  logic [`XLEN-1:0]        wr_data_wb,
	input  decode_pkg::reg_tag_t    rd_wb,
	output logic                    dec_valid,
	output decode_pkg::alu_op_t     alu_op_ex,
	output decode_pkg::branch_op_t  branch_op_ex,
	output logic [`XLEN-1:0]        src_data1_ex,
	output logic [`XLEN-1:0]        src_data2_ex,
	output logic [`XLEN-1:0]        imm_ex,
	output logic [`XLEN-1:0]        store_data_ex,
	output logic [`XLEN-1:0]        pc_ex,
	output logic                    load_ex,
	output logic                    store_ex,
	output logic                    jalr_ex,
	output decode_pkg::mem_size_t   mem_size_ex,
	output logic                    mem_unsigned_ex,
	output decode_pkg::reg_tag_t    rd_ex
);

	// per-source operand signals, index 0 is rs1
	logic [`REG_IDX_W-1:0] rs_idx [2];
	logic                  rs_used [2];
	logic [`XLEN-1:0]      rf_data [2];
	logic [`XLEN-1:0]      fwd_data [2];
	logic                  load_hazard [2];

	decode_pkg::src1_sel_t  src1_sel;
	decode_pkg::src2_sel_t  src2_sel;
	logic [`XLEN-1:0]       imm;
	decode_pkg::alu_op_t    alu_op;
	decode_pkg::branch_op_t branch_op;
	logic                   is_load, is_store, is_jal, is_jalr;
	decode_pkg::mem_size_t  mem_size;
	logic                   mem_unsigned;
	decode_pkg::reg_tag_t   rd_tag;

	instr_decoder i_instr_decoder
	(
		.if_valid     (if_valid),
		.instr_dec    (instr_dec),
		.rs1_idx      (rs_idx[0]),
		.rs2_idx      (rs_idx[1]),
		.rs1_used     (rs_used[0]),
		.rs2_used     (rs_used[1]),
		.src1_sel     (src1_sel),
		.src2_sel     (src2_sel),
		.imm          (imm),
		.alu_op       (alu_op),
		.branch_op    (branch_op),
		.is_load      (is_load),
		.is_store     (is_store),
		.is_jal       (is_jal),
		.is_jalr      (is_jalr),
		.mem_size     (mem_size),
		.mem_unsigned (mem_unsigned),
		.rd_tag       (rd_tag)
	);

	reg_file i_reg_file
	(
		.cpu_clk  (cpu_clk),
		.cpu_rstn (cpu_rstn),
		.wr_valid (wr_valid_wb),
		.wr_tag   (rd_wb),
		.wr_data  (wr_data_wb),
		.rs1_idx  (rs_idx[0]),
		.rs2_idx  (rs_idx[1]),
		.rf_data1 (rf_data[0]),
		.rf_data2 (rf_data[1])
	);

	for (genvar s = 0; s < 2; s++)
	begin : g_src
		operand_select i_operand_select
		(
			.rs_idx         (rs_idx[s]),
			.rs_used        (rs_used[s]),
			.rf_data        (rf_data[s]),
			.rd_ex          (rd_ex), // from our own EX register
			.load_ex        (load_ex),
			.alu_result_ex  (alu_result_ex),
			.rd_mem         (rd_mem),
			.data_mem       (data_mem),
			.load_wait_data (load_wait_data),
			.wr_valid_wb    (wr_valid_wb),
			.rd_wb          (rd_wb),
			.wr_data_wb     (wr_data_wb),
			.fwd_data       (fwd_data[s]),
			.load_hazard    (load_hazard[s])
		);
	end

	ex_stage_reg i_ex_stage_reg
	(
		.cpu_clk         (cpu_clk),
		.cpu_rstn        (cpu_rstn),
		.if_valid        (if_valid),
		.pc_dec          (pc_dec),
		.src1_sel        (src1_sel),
		.src2_sel        (src2_sel),
		.imm             (imm),
		.alu_op          (alu_op),
		.branch_op       (branch_op),
		.is_load         (is_load),
		.is_store        (is_store),
		.is_jal          (is_jal),
		.is_jalr         (is_jalr),
		.mem_size        (mem_size),
		.mem_unsigned    (mem_unsigned),
		.rd_tag          (rd_tag),
		.fwd_data1       (fwd_data[0]),
		.fwd_data2       (fwd_data[1]),
		.load_hazard1    (load_hazard[0]),
		.load_hazard2    (load_hazard[1]),
		.ex_ready        (ex_ready),
		.branch_taken_ex (branch_taken_ex),
		.exception_met   (exception_met),
		.dec_ready       (dec_ready),
		.jal_dec         (jal_dec),
		.dec_valid       (dec_valid),
		.alu_op_ex       (alu_op_ex),
		.branch_op_ex    (branch_op_ex),
		.src_data1_ex    (src_data1_ex),
		.src_data2_ex    (src_data2_ex),
		.imm_ex          (imm_ex),
		.store_data_ex   (store_data_ex),
		.pc_ex           (pc_ex),
		.load_ex         (load_ex),
		.store_ex        (store_ex),
		.jalr_ex         (jalr_ex),
		.mem_size_ex     (mem_size_ex),
		.mem_unsigned_ex (mem_unsigned_ex),
		.rd_ex           (rd_ex)
	);

endmodule

//--- bench/decode_stage_props.sv
`include "decode_settings.svh"

module decode_stage_props
(
	input  logic                    cpu_clk,
	input  logic                    cpu_rstn,
	input  logic                    ex_ready,
	input  logic                    branch_taken_ex,
	input  logic                    exception_met,
	input  logic                    jalr_ex,
	input  logic                    dec_ready,
	input  decode_pkg::alu_op_t     alu_op_ex,
	input  decode_pkg::reg_tag_t    rd_ex,
	input  logic [`XLEN-1:0]        src_data1_ex,
	input  logic [`XLEN-1:0]        src_data2_ex,
	input  logic [`XLEN-1:0]        imm_ex,
	input  logic [`XLEN-1:0]        pc_ex
);
	timeunit 1ns;
	timeprecision 100ps;

	logic flush;

	assign flush = branch_taken_ex | exception_met | jalr_ex;

	// a flushed slot carries no operation and no destination
	flush_clears: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		flush |=> (alu_op_ex == decode_pkg::ALU_NONE && rd_ex == `NO_RD))
		else $error("flush did not clear the EX control outputs");

	hold_stable: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		(!ex_ready && !flush) |=> ($stable(alu_op_ex) && $stable(rd_ex) &&
		$stable(src_data1_ex) && $stable(src_data2_ex) && $stable(imm_ex) &&
		$stable(pc_ex)))
		else $error("EX outputs changed while ex_ready was low");

	ready_backpressure: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
		!ex_ready |-> !dec_ready)
		else $error("dec_ready high while ex_ready low");

endmodule

//--- bench/decode_stage_tb.sv
`include "decode_settings.svh"

module decode_stage_tb;
	timeunit 1ns;
	timeprecision 100ps;

	logic cpu_clk, cpu_rstn;
	logic if_valid, ex_ready, branch_taken_ex, exception_met;
	logic load_wait_data, wr_valid_wb;
	logic [`XLEN-1:0] instr_dec, pc_dec, alu_result_ex, data_mem, wr_data_wb;
	decode_pkg::reg_tag_t rd_mem, rd_wb;
	logic dec_ready, jal_dec, dec_valid;
	decode_pkg::alu_op_t alu_op_ex;
	decode_pkg::branch_op_t branch_op_ex;
	logic [`XLEN-1:0] src_data1_ex, src_data2_ex, imm_ex, store_data_ex, pc_ex;
	logic load_ex, store_ex, jalr_ex, mem_unsigned_ex;
	decode_pkg::mem_size_t mem_size_ex;
	decode_pkg::reg_tag_t rd_ex;

	logic [31:0] steps [64][20]; // one row per line of the data file
	int nsteps = 0;
	int cycles = 0;
	int limit = 0;
	int errors = 0;
	int checks = 0;
	int test_errs = 0;
	int tests_run = 0;
	int tests_bad = 0;

	// expected EX slot for outputs that the data file has no column for
	logic exp_valid, exp_load, exp_store, exp_jalr, exp_unsigned;
	decode_pkg::branch_op_t exp_branch;
	decode_pkg::mem_size_t exp_size;
	logic [31:0] exp_pc, exp_store_data;
	decode_pkg::reg_tag_t exp_rd;
	logic [31:0] shadow_regs [32]; // register contents seen by decode

	decode_stage i_decode_stage (.*);

	bind decode_stage decode_stage_props i_decode_stage_props (.*);

	always #2 cpu_clk = ~cpu_clk;

	// runaway guard, limit set once the steps are known
	always @(posedge cpu_clk)
	begin
		cycles++;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic read_tests();
		int fd;
		int n;
		string line;
		logic [31:0] f [20];
		fd = $fopen("bench/decode_tests.txt", "r");
		if (fd == 0)
			$display("cannot open bench/decode_tests.txt");
		else
		begin
			while (!$feof(fd) && nsteps < 64)
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() < 2 || line.getc(0) == "#")
					continue; // blank or column description
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
					f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19]);
				if (n == 20)
				begin
					for (int i = 0; i < 20; i++)
						steps[nsteps][i] = f[i];
					nsteps++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_step(int k);
		if_valid        <= steps[k][1][0];
		instr_dec       <= steps[k][2];
		pc_dec          <= steps[k][3];
		ex_ready        <= steps[k][4][0];
		branch_taken_ex <= steps[k][5][0];
		exception_met   <= steps[k][6][0];
		alu_result_ex   <= steps[k][7];
		rd_mem          <= steps[k][8][5:0];
		data_mem        <= steps[k][9];
		load_wait_data  <= steps[k][10][0];
		wr_valid_wb     <= steps[k][11][0];
		rd_wb           <= steps[k][12][5:0];
		wr_data_wb      <= steps[k][13];
	endtask

	task automatic drive_idle();
		if_valid        <= 1'b0;
		instr_dec       <= '0;
		ex_ready        <= 1'b1;
		branch_taken_ex <= 1'b0;
		exception_met   <= 1'b0;
		load_wait_data  <= 1'b0;
		wr_valid_wb     <= 1'b0;
		rd_mem          <= `NO_RD;
		rd_wb           <= `NO_RD;
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, expected, actual);
			errors++;
			test_errs++;
		end
	endtask

	// EX outputs from the instruction of step k
	task automatic check_ex(int k);
		check_value("alu_op_ex", steps[k][15], 32'(alu_op_ex));
		check_value("src_data1_ex", steps[k][16], src_data1_ex);
		check_value("src_data2_ex", steps[k][17], src_data2_ex);
		check_value("imm_ex", steps[k][18], imm_ex);
		check_value("rd_ex", steps[k][19], 32'(rd_ex));
	endtask

	// rs2 of step k, youngest producer first
	function automatic logic [31:0] forwarded_rs2(int k);
		decode_pkg::reg_tag_t idx;
		idx = {1'b0, steps[k][2][24:20]};
		if (idx == '0)
			return '0;
		else if (idx == exp_rd && !exp_load)
			return steps[k][7];
		else if (idx == steps[k][8][5:0])
			return steps[k][9];
		else if (idx == steps[k][12][5:0] && steps[k][11][0])
			return steps[k][13];
		else
			return shadow_regs[idx];
	endfunction

	// what the EX slot holds after the edge that ends step k
	task automatic advance_model(int k);
		logic [31:0] instr;
		logic flush;
		instr = steps[k][2];
		flush = steps[k][5][0] | steps[k][6][0] | exp_jalr;
		if (flush || (steps[k][4][0] && !(steps[k][1][0] && steps[k][14][0])))
		begin
			exp_valid      = 1'b0;
			exp_load       = 1'b0;
			exp_store      = 1'b0;
			exp_jalr       = 1'b0;
			exp_branch     = decode_pkg::BR_NONE;
			exp_store_data = '0;
		end
		else if (steps[k][4][0])
		begin
			exp_store_data = forwarded_rs2(k); // uses the slot before this edge
			exp_valid      = 1'b1;
			exp_load       = (instr[6:0] == `OPC_LOAD);
			exp_store      = (instr[6:0] == `OPC_STORE);
			exp_jalr       = (instr[6:0] == `OPC_JALR);
			exp_unsigned   = exp_load && instr[14];
			exp_pc         = steps[k][3];
			exp_branch     = decode_pkg::BR_NONE;
			if (instr[6:0] == `OPC_BRANCH)
				case (instr[14:12])
					`F3_BEQ:  exp_branch = decode_pkg::BR_EQ;
					`F3_BNE:  exp_branch = decode_pkg::BR_NE;
					`F3_BLT:  exp_branch = decode_pkg::BR_LT;
					`F3_BGE:  exp_branch = decode_pkg::BR_GE;
					`F3_BLTU: exp_branch = decode_pkg::BR_LTU;
					`F3_BGEU: exp_branch = decode_pkg::BR_GEU;
				endcase
			case (instr[13:12])
				2'b00:   exp_size = decode_pkg::MEM_BYTE;
				2'b01:   exp_size = decode_pkg::MEM_HALF;
				default: exp_size = decode_pkg::MEM_WORD;
			endcase
		end
		exp_rd = steps[k][19][5:0];
		// writeback lands in the register file at the same edge
		if (steps[k][11][0] && steps[k][12][5:0] != '0 && steps[k][12][5:0] < 32)
			shadow_regs[steps[k][12][4:0]] = steps[k][13];
	endtask

	task automatic check_slot();
		check_value("dec_valid", exp_valid, dec_valid);
		check_value("load_ex", exp_load, load_ex);
		check_value("store_ex", exp_store, store_ex);
		check_value("jalr_ex", exp_jalr, jalr_ex);
		check_value("branch_op_ex", 32'(exp_branch), 32'(branch_op_ex));
		check_value("pc_ex", exp_pc, pc_ex);
		if (exp_load || exp_store)
		begin
			check_value("mem_size_ex", 32'(exp_size), 32'(mem_size_ex));
			check_value("mem_unsigned_ex", exp_unsigned, mem_unsigned_ex);
		end
		if (exp_store)
			check_value("store_data_ex", exp_store_data, store_data_ex);
	endtask

	task automatic report_test(int num);
		tests_run++;
		if (test_errs == 0)
			$display("test %0d ok", num);
		else
		begin
			$display("test %0d had %0d errors", num, test_errs);
			tests_bad++;
		end
		test_errs = 0;
	endtask

	initial
	begin
		cpu_clk = 1'b0;
		cpu_rstn = 1'b0;
		if_valid = 1'b0;
		instr_dec = '0;
		pc_dec = '0;
		ex_ready = 1'b1;
		branch_taken_ex = 1'b0;
		exception_met = 1'b0;
		alu_result_ex = '0;
		rd_mem = `NO_RD;
		data_mem = '0;
		load_wait_data = 1'b0;
		wr_valid_wb = 1'b0;
		rd_wb = `NO_RD;
		wr_data_wb = '0;

		exp_valid = 1'b0;
		exp_load = 1'b0;
		exp_store = 1'b0;
		exp_jalr = 1'b0;
		exp_branch = decode_pkg::BR_NONE;
		exp_store_data = '0;
		exp_rd = `NO_RD;
		for (int i = 0; i < 32; i++)
			shadow_regs[i] = '0;

		read_tests();
		limit = nsteps * 2 + 20;
		if (nsteps == 0)
		begin
			$display("no test steps found in the data file");
			$display("Regression failed");
			$finish;
		end
		else
		begin
			repeat (2) @(posedge cpu_clk);
			cpu_rstn <= 1'b1;

			for (int k = 0; k <= nsteps; k++)
			begin
				@(posedge cpu_clk);
				if (k < nsteps)
					drive_step(k);
				else
					drive_idle();
				@(negedge cpu_clk); // outputs settled mid-cycle
				if (k > 0)
				begin
					check_ex(k - 1);
					check_slot();
					if (k == nsteps || steps[k][0] != steps[k-1][0])
						report_test(steps[k-1][0]);
				end
				if (k < nsteps)
				begin
					check_value("dec_ready", steps[k][14], 32'(dec_ready));
					check_value("jal_dec",
						steps[k][1][0] && steps[k][2][6:0] == `OPC_JAL, jal_dec);
					advance_model(k);
				end
			end

			$display("%0d tests, %0d failed, %0d checks, %0d errors",
				tests_run, tests_bad, checks, errors);
			if (errors == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
			$finish;
		end
	end

endmodule

//--- files.f
+incdir+include
verilog/decode_pkg.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/operand_select.sv
verilog/ex_stage_reg.sv
verilog/decode_stage.sv
bench/decode_stage_props.sv
bench/decode_stage_tb.sv

//--- bench/decode_tests.txt
# test if_valid instr pc ex_ready branch_taken exception alu_result rd_mem data_mem load_wait wb_valid rd_wb wb_data
#  then expected: dec_ready alu_op src_data1 src_data2 imm rd (EX values one cycle later)
1 1 00500093 00000000 1 0 0 00000000 20 00000000 0 0 20 00000000 1 1 00000000 00000005 00000005 01
1 1 12345137 00000004 1 0 0 00000000 20 00000000 0 0 20 00000000 1 0 00000000 12345000 12345000 02
1 1 00001197 00000100 1 0 0 00000000 20 00000000 0 0 20 00000000 1 1 00000100 00001000 00001000 03
1 1 40218233 00000104 1 0 0 00001100 20 00000000 0 0 20 00000000 1 2 00001100 00000000 00000000 04
1 1 4020D2B3 00000108 1 0 0 00000000 20 00000000 0 0 20 00000000 1 a 00000000 00000000 00000000 05
1 1 FFF02313 0000010c 1 0 0 00000000 20 00000000 0 0 20 00000000 1 3 00000000 ffffffff ffffffff 06
2 1 00038413 00000110 1 0 0 00000000 20 00000000 0 1 07 deadbeef 1 1 deadbeef 00000000 00000000 08
2 1 000384B3 00000114 1 0 0 00000000 20 00000000 0 0 20 00000000 1 1 deadbeef 00000000 00000000 09
2 1 00000533 00000118 1 0 0 00000000 20 00000000 0 1 00 00000055 1 1 00000000 00000000 00000000 0a
3 1 00150593 0000011c 1 0 0 00001111 0a 00002222 0 1 0a 00003333 1 1 00001111 00000001 00000001 0b
3 1 00002603 00000120 1 0 0 00000000 20 00000000 0 0 20 00000000 1 1 00000000 00000000 00000000 0c
4 1 00B606B3 00000124 1 0 0 00000000 20 00000000 0 0 20 00000000 0 0 00000000 00000000 00000000 20
4 1 00B606B3 00000124 1 0 0 00000000 0c abcd0123 0 1 0b 00000077 1 1 abcd0123 00000077 00000000 0d
5 1 0F006713 00000128 1 1 0 00000000 20 00000000 0 0 20 00000000 1 0 00000000 00000000 00000000 20
5 1 0F006713 00000128 1 0 0 00000000 20 00000000 0 0 20 00000000 1 6 00000000 000000f0 000000f0 0e
5 1 00104793 0000012c 0 0 0 00000000 20 00000000 0 0 20 00000000 0 6 00000000 000000f0 000000f0 0e
5 1 00104793 0000012c 1 0 0 00000000 20 00000000 0 0 20 00000000 1 7 00000000 00000001 00000001 0f
6 1 00208463 00000200 1 0 0 00000000 20 00000000 0 0 20 00000000 1 2 00000000 00000000 00000008 20
6 1 010000EF 00000208 1 0 0 00000000 20 00000000 0 0 20 00000000 1 0 00000000 0000020c 00000010 01
6 1 00028067 00000300 1 0 0 00000000 20 00000000 0 0 20 00000000 1 0 00000000 00000304 00000000 00
6 1 00300813 00000304 1 0 0 00000000 20 00000000 0 0 20 00000000 1 0 00000000 00000000 00000000 20
6 1 00B01223 00000308 1 0 0 00000000 0b 1234beef 0 0 20 00000000 1 1 00000000 00000004 00000004 20
